/* conv_pkg.sv */
package conv_pkg;

    // ========================================================================
    // geometry
    // ========================================================================

    // one pixel or one kernel weight
    parameter int PIX_W       = 3;
    // square input matrix, one row per input word
    parameter int MAT_DIM     = 6;
    // one kernel per input word
    parameter int NUM_KERNELS = 6;
    // valid 2x2 window positions along each axis
    parameter int WIN_DIM     = MAT_DIM - 1;

    parameter int ROW_W = MAT_DIM * PIX_W;
    parameter int KER_W = 4 * PIX_W;

    // worst case sum is 4 * 7 * 7 = 196
    parameter int RES_W = 8;

    // row, kernel and window position indices
    parameter int IDX_W = 3;

    // ========================================================================
    // types
    // ========================================================================

    typedef logic [PIX_W-1:0] pixel_t;

    // entry order: (y,x), (y,x+1), (y+1,x), (y+1,x+1)
    typedef pixel_t [3:0] window_t;

    typedef logic [RES_W-1:0] res_t;

    typedef enum logic {
        ST_LOAD = 1'b0,
        ST_CONV = 1'b1
    } conv_state_e;

endpackage

/* conv_matrix_store.sv */
`timescale 1ns/1ps

module conv_matrix_store (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_wr_en,
    input  logic [conv_pkg::IDX_W-1:0] i_wr_idx,
    input  logic [conv_pkg::ROW_W-1:0] i_row,
    input  logic [conv_pkg::IDX_W-1:0] i_win_y,
    input  logic [conv_pkg::IDX_W-1:0] i_win_x,
    output conv_pkg::window_t          o_window
);

    import conv_pkg::*;

    pixel_t mat [MAT_DIM][MAT_DIM];
    pixel_t row_pix [MAT_DIM];

    logic [IDX_W-1:0] win_y_nxt;
    logic [IDX_W-1:0] win_x_nxt;

    // column c sits in bits 3c+2 .. 3c of the row word
    always_comb begin
        for (int c = 0; c < MAT_DIM; c++) begin
            row_pix[c] = i_row[c*PIX_W +: PIX_W];
        end
    end

    // ========================================================================
    // row write
    // ========================================================================

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            for (int c = 0; c < MAT_DIM; c++) begin
                mat[i_wr_idx][c] <= row_pix[c];
            end
        end
    end

    // ========================================================================
    // 2x2 window read
    // ========================================================================

    // neighbours of the window origin, max position is 4 so 3 bits suffice
    assign win_y_nxt = i_win_y + 1'b1;
    assign win_x_nxt = i_win_x + 1'b1;

    always_comb begin
        o_window[0] = mat[i_win_y][i_win_x];
        o_window[1] = mat[i_win_y][win_x_nxt];
        o_window[2] = mat[win_y_nxt][i_win_x];
        o_window[3] = mat[win_y_nxt][win_x_nxt];
    end

    // the engine must never address a row outside the matrix
    a_wr_idx_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        i_wr_en |-> (i_wr_idx < IDX_W'(MAT_DIM))
    ) else $error("matrix store write to row %0d", i_wr_idx);

endmodule

/* conv_kernel_store.sv */
`timescale 1ns/1ps

module conv_kernel_store (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_wr_en,
    input  logic [conv_pkg::IDX_W-1:0] i_wr_idx,
    input  logic [conv_pkg::KER_W-1:0] i_kernel,
    input  logic [conv_pkg::IDX_W-1:0] i_kernel_idx,
    output conv_pkg::window_t          o_weights
);

    import conv_pkg::*;

    window_t kernels [NUM_KERNELS];
    window_t ker_unpacked;

    // weight 0 top-left in the lowest field, weight 3 bottom-right on top
    always_comb begin
        for (int w = 0; w < 4; w++) begin
            ker_unpacked[w] = i_kernel[w*PIX_W +: PIX_W];
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            kernels[i_wr_idx] <= ker_unpacked;
        end
    end

    // kernel select for the window engine
    assign o_weights = kernels[i_kernel_idx];

    // ========================================================================
    // index checks
    // ========================================================================

    a_wr_idx_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        i_wr_en |-> (i_wr_idx < IDX_W'(NUM_KERNELS))
    ) else $error("kernel store write to slot %0d", i_wr_idx);

    // read index wraps at the last kernel, never past it
    a_rd_idx_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        i_kernel_idx < IDX_W'(NUM_KERNELS)
    ) else $error("kernel store read from slot %0d", i_kernel_idx);

endmodule

/* conv_window_engine.sv */
`timescale 1ns/1ps

module conv_window_engine #(
    parameter int NUM_CREDITS = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_in_valid,
    input  conv_pkg::window_t          i_window,
    input  conv_pkg::window_t          i_weights,
    input  logic                       i_credit_return,
    output logic                       o_wr_en,
    output logic [conv_pkg::IDX_W-1:0] o_wr_idx,
    output logic [conv_pkg::IDX_W-1:0] o_win_y,
    output logic [conv_pkg::IDX_W-1:0] o_win_x,
    output logic [conv_pkg::IDX_W-1:0] o_kernel_idx,
    output logic                       o_out_valid,
    output conv_pkg::res_t             o_out_data,
    output logic                       o_busy
);

    import conv_pkg::*;

    localparam int CRED_W = $clog2(NUM_CREDITS + 1);

    // last row word and last kernel share one index
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_KERNELS - 1);
    localparam logic [IDX_W-1:0] LAST_POS = IDX_W'(WIN_DIM - 1);

    conv_state_e state;

    logic [IDX_W-1:0]  load_cnt;
    logic              accept;
    logic              issue;
    logic              last_pos;
    logic              done;
    logic [CRED_W-1:0] credit_cnt;
    logic [CRED_W-1:0] credit_nxt;
    res_t              conv_sum;

    // ========================================================================
    // load phase
    // ========================================================================

    // words offered while convolving are dropped
    assign accept   = i_in_valid && (state == ST_LOAD);
    assign o_wr_en  = accept;
    assign o_wr_idx = load_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_LOAD;
            load_cnt <= '0;
            o_busy   <= 1'b0;
        end else begin
            case (state)
                ST_LOAD: begin
                    if (accept) begin
                        o_busy <= 1'b1;
                        if (load_cnt == LAST_IDX) begin
                            load_cnt <= '0;
                            state    <= ST_CONV;
                        end else begin
                            load_cnt <= load_cnt + 1'b1;
                        end
                    end
                end
                ST_CONV: begin
                    // job ends once the final result has left
                    if (o_out_valid && done) begin
                        state  <= ST_LOAD;
                        o_busy <= 1'b0;
                    end
                end
                default: state <= ST_LOAD;
            endcase
        end
    end

    // ========================================================================
    // credit tracking
    // ========================================================================

    // credits left after this cycle's result and return
    assign credit_nxt = credit_cnt - CRED_W'(o_out_valid) + CRED_W'(i_credit_return);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CRED_W'(NUM_CREDITS);
        end else begin
            credit_cnt <= credit_nxt;
        end
    end

    // a result issued now is presented next cycle, so it needs a credit then
    assign issue = (state == ST_CONV) && !done && (credit_nxt != '0);

    // ========================================================================
    // position counters, x inner, then y, then kernel
    // ========================================================================

    assign last_pos = (o_win_x == LAST_POS) && (o_win_y == LAST_POS) &&
                      (o_kernel_idx == LAST_IDX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_win_x      <= '0;
            o_win_y      <= '0;
            o_kernel_idx <= '0;
            done         <= 1'b0;
        end else if (issue) begin
            if (o_win_x != LAST_POS) begin
                o_win_x <= o_win_x + 1'b1;
            end else begin
                o_win_x <= '0;
                if (o_win_y != LAST_POS) begin
                    o_win_y <= o_win_y + 1'b1;
                end else begin
                    o_win_y <= '0;
                    if (o_kernel_idx != LAST_IDX) begin
                        o_kernel_idx <= o_kernel_idx + 1'b1;
                    end else begin
                        o_kernel_idx <= '0;
                    end
                end
            end
            if (last_pos) begin
                done <= 1'b1;
            end
        end else if (o_out_valid && done) begin
            done <= 1'b0;
        end
    end

    // ========================================================================
    // multiply-add and output register
    // ========================================================================

    always_comb begin
        conv_sum = '0;
        for (int i = 0; i < 4; i++) begin
            conv_sum = conv_sum + res_t'(i_window[i]) * res_t'(i_weights[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_out_valid <= 1'b0;
        end else begin
            o_out_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            o_out_data <= conv_sum;
        end
    end

    // receiver must never hand back more credits than it owns
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        credit_cnt <= CRED_W'(NUM_CREDITS)
    ) else $error("credit count %0d above limit", credit_cnt);

    a_valid_needs_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        o_out_valid |-> (credit_cnt != '0) || i_credit_return
    ) else $error("result sent without a credit");

endmodule

/* conv_top.sv */
`timescale 1ns/1ps

module conv_top #(
    parameter int NUM_CREDITS = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_in_valid,
    input  logic [conv_pkg::ROW_W-1:0] i_row,
    input  logic [conv_pkg::KER_W-1:0] i_kernel,
    input  logic                       i_credit_return,
    output logic                       o_out_valid,
    output conv_pkg::res_t             o_out_data,
    output logic                       o_busy
);

    import conv_pkg::*;

    // store writes from the engine
    logic             wr_en;
    logic [IDX_W-1:0] wr_idx;

    // window and kernel reads
    logic [IDX_W-1:0] win_y;
    logic [IDX_W-1:0] win_x;
    logic [IDX_W-1:0] kernel_idx;
    window_t          window;
    window_t          weights;

    conv_matrix_store conv_matrix_store_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wr_en  (wr_en),
        .i_wr_idx (wr_idx),
        .i_row    (i_row),
        .i_win_y  (win_y),
        .i_win_x  (win_x),
        .o_window (window)
    );

    conv_kernel_store conv_kernel_store_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_wr_en      (wr_en),
        .i_wr_idx     (wr_idx),
        .i_kernel     (i_kernel),
        .i_kernel_idx (kernel_idx),
        .o_weights    (weights)
    );

    conv_window_engine #(
        .NUM_CREDITS (NUM_CREDITS)
    ) conv_window_engine_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_in_valid      (i_in_valid),
        .i_window        (window),
        .i_weights       (weights),
        .i_credit_return (i_credit_return),
        .o_wr_en         (wr_en),
        .o_wr_idx        (wr_idx),
        .o_win_y         (win_y),
        .o_win_x         (win_x),
        .o_kernel_idx    (kernel_idx),
        .o_out_valid     (o_out_valid),
        .o_out_data      (o_out_data),
        .o_busy          (o_busy)
    );

endmodule

/* tb_conv.sv */
`timescale 1ns/1ps

module tb_conv;

    import conv_pkg::*;

    localparam int NUM_CREDITS = 4;
    localparam int RES_PER_JOB = NUM_KERNELS * WIN_DIM * WIN_DIM;
    localparam int MAX_JOBS    = 16;
    localparam int HOLD_CYCLES = 20;

    logic             clk;
    logic             rst_n;
    logic             i_in_valid;
    logic [ROW_W-1:0] i_row;
    logic [KER_W-1:0] i_kernel;
    logic             i_credit_return;
    logic             o_out_valid;
    res_t             o_out_data;
    logic             o_busy;

    // jobs from the data file
    logic [ROW_W-1:0] job_rows [MAX_JOBS][MAT_DIM];
    logic [KER_W-1:0] job_kers [MAX_JOBS][NUM_KERNELS];
    int               job_mode [MAX_JOBS];
    int               job_extra [MAX_JOBS];
    int               job_sum [MAX_JOBS];
    int               job_xor [MAX_JOBS];
    int               num_jobs;

    int          cycle_limit = 0;
    int          cycle_cnt = 0;
    int          error_cnt = 0;
    int          result_cnt = 0;
    int          exp_res [RES_PER_JOB];
    int          res_idx;
    int          got_sum;
    int          got_xor;
    int          owed = 0;
    int          hold_cnt = 0;
    int          credit_mode = 0;
    logic        ret_next = 1'b0;

    conv_top #(
        .NUM_CREDITS (NUM_CREDITS)
    ) conv_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_in_valid      (i_in_valid),
        .i_row           (i_row),
        .i_kernel        (i_kernel),
        .i_credit_return (i_credit_return),
        .o_out_valid     (o_out_valid),
        .o_out_data      (o_out_data),
        .o_busy          (o_busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ========================================================================
    // data file and reference model
    // ========================================================================

    task automatic read_tests();
        int    fd;
        int    n;
        string line;
        num_jobs = 0;
        fd = $fopen("conv_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open conv_tests.txt");
            return;
        end
        while (!$feof(fd) && num_jobs < MAX_JOBS) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %d %d %d %h",
                    job_rows[num_jobs][0], job_rows[num_jobs][1], job_rows[num_jobs][2],
                    job_rows[num_jobs][3], job_rows[num_jobs][4], job_rows[num_jobs][5],
                    job_kers[num_jobs][0], job_kers[num_jobs][1], job_kers[num_jobs][2],
                    job_kers[num_jobs][3], job_kers[num_jobs][4], job_kers[num_jobs][5],
                    job_mode[num_jobs], job_extra[num_jobs],
                    job_sum[num_jobs], job_xor[num_jobs]);
                if (n == 16) begin
                    num_jobs++;
                end else begin
                    $display("malformed line in conv_tests.txt: %s", line);
                    error_cnt++;
                end
            end
        end
        $fclose(fd);
    endtask

    // column c of a row word sits at bits 3c+2 .. 3c
    function automatic int pixel_at(input int j, input int y, input int x);
        return int'(job_rows[j][y][x*PIX_W +: PIX_W]);
    endfunction

    // weight 0 top-left in the lowest field
    function automatic int weight_at(input int j, input int k, input int i);
        return int'(job_kers[j][k][i*PIX_W +: PIX_W]);
    endfunction

    task automatic compute_reference(input int j);
        int idx;
        idx = 0;
        for (int k = 0; k < NUM_KERNELS; k++) begin
            for (int y = 0; y < WIN_DIM; y++) begin
                for (int x = 0; x < WIN_DIM; x++) begin
                    exp_res[idx] = weight_at(j, k, 0) * pixel_at(j, y, x)
                                 + weight_at(j, k, 1) * pixel_at(j, y, x + 1)
                                 + weight_at(j, k, 2) * pixel_at(j, y + 1, x)
                                 + weight_at(j, k, 3) * pixel_at(j, y + 1, x + 1);
                    idx++;
                end
            end
        end
    endtask

    // ========================================================================
    // per-cycle driving, result checks and credit return
    // ========================================================================

    function automatic logic next_credit_return();
        logic ret;
        case (credit_mode)
            0: ret = (owed > 0);
            1: begin
                // hold phase, then a short release window
                ret = (hold_cnt >= HOLD_CYCLES) && (owed > 0);
                hold_cnt = (hold_cnt == HOLD_CYCLES + NUM_CREDITS - 1) ? 0 : hold_cnt + 1;
            end
            default: ret = (owed > 0) && ($urandom % 3 != 0);
        endcase
        return ret;
    endfunction

    task automatic check_result();
        int got;
        got = int'(o_out_data);
        result_cnt++;
        if (res_idx >= RES_PER_JOB) begin
            $display("ERROR %0t: result %0d beyond the end of the job", $time, res_idx + 1);
            error_cnt++;
        end else if (got != exp_res[res_idx]) begin
            $display("ERROR %0t: kernel %0d y %0d x %0d got %0d expected %0d", $time,
                     res_idx / (WIN_DIM * WIN_DIM), (res_idx / WIN_DIM) % WIN_DIM,
                     res_idx % WIN_DIM, got, exp_res[res_idx]);
            error_cnt++;
        end
        got_sum += got;
        got_xor ^= got;
        res_idx++;
    endtask

    // drive shortly after the rising edge, sample at the falling edge
    task automatic step_cycle(input logic in_valid, input logic [ROW_W-1:0] row,
                              input logic [KER_W-1:0] ker);
        @(posedge clk);
        #5;
        i_in_valid      = in_valid;
        i_row           = row;
        i_kernel        = ker;
        i_credit_return = ret_next;
        @(negedge clk);
        if (o_out_valid && !o_busy) begin
            $display("ERROR %0t: result presented while not busy", $time);
            error_cnt++;
        end
        if (o_out_valid) begin
            check_result();
        end
        owed = owed + int'(o_out_valid) - int'(i_credit_return);
        if (owed > NUM_CREDITS) begin
            $display("ERROR %0t: %0d results outstanding, limit %0d", $time, owed,
                     NUM_CREDITS);
            error_cnt++;
        end
        ret_next = next_credit_return();
    endtask

    task automatic run_job(input int j);
        logic extra;
        compute_reference(j);
        res_idx     = 0;
        got_sum     = 0;
        got_xor     = 0;
        credit_mode = job_mode[j];
        hold_cnt    = 0;
        for (int w = 0; w < NUM_KERNELS; w++) begin
            step_cycle(1'b1, job_rows[j][w], job_kers[j][w]);
            if ((w == 0 && o_busy) || (w > 0 && !o_busy)) begin
                $display("ERROR %0t: job %0d busy %0b after word %0d", $time, j, o_busy, w);
                error_cnt++;
            end
        end
        while (res_idx < RES_PER_JOB) begin
            // stray words well inside the convolve phase
            extra = (job_extra[j] != 0) && (res_idx >= 10) && (res_idx < 100) &&
                    ($urandom % 2 == 1);
            step_cycle(extra, ROW_W'($urandom), KER_W'($urandom));
            if (!o_busy) begin
                $display("ERROR %0t: job %0d busy low before result %0d", $time, j,
                         res_idx + 1);
                error_cnt++;
            end
        end
        step_cycle(1'b0, '0, '0);
        if (o_busy) begin
            $display("ERROR %0t: job %0d busy still high after the last result", $time, j);
            error_cnt++;
        end
        if (got_sum != job_sum[j] || got_xor != job_xor[j]) begin
            $display("ERROR %0t: job %0d sum %0d xor %0h, file gives %0d and %0h", $time,
                     j, got_sum, got_xor, job_sum[j], job_xor[j]);
            error_cnt++;
        end
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================

    initial begin
        void'($urandom(32'hb93a728f));
        rst_n           = 1'b0;
        i_in_valid      = 1'b0;
        i_row           = '0;
        i_kernel        = '0;
        i_credit_return = 1'b0;
        read_tests();
        cycle_limit = num_jobs * RES_PER_JOB * 25 + 1000;
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        @(negedge clk);
        if (o_out_valid || o_busy) begin
            $display("ERROR %0t: outputs not idle after reset", $time);
            error_cnt++;
        end
        if (num_jobs == 0) begin
            $display("no test jobs were read from conv_tests.txt");
            error_cnt++;
        end else begin
            for (int j = 0; j < num_jobs; j++) begin
                run_job(j);
            end
        end
        $display("%0d jobs, %0d results checked, %0d errors", num_jobs, result_cnt,
                 error_cnt);
        if (error_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* conv_tests.txt */
# columns: row words 0-5 (hex), kernel words 0-5 (hex), credit mode, stray words,
#          sum of all 150 results (dec), xor of all 150 results (hex)
# credit mode 0 returns at once, 1 holds for 20 cycles, 2 returns at random
# stray words 1 offers extra input words while the engine convolves
#
# all pixels 1, uniform kernels of weight 1 to 6
09249 09249 09249 09249 09249 09249 249 492 6DB 924 B6D DB6 0 0 2100 1C
# pixel equals its column, single weight kernels then all 7 then 1 2 3 4
2C688 2C688 2C688 2C688 2C688 2C688 001 008 040 200 FFF 8D1 1 1 2650 78
# pixel equals its row, same kernels
00000 09249 12492 1B6DB 24924 2DB6D 001 008 040 200 FFF 8D1 2 0 2675 79
# largest pixels and weights, every result 196
3FFFF 3FFFF 3FFFF 3FFFF 3FFFF 3FFFF FFF FFF FFF FFF FFF FFF 1 1 29400 00
# column ramp again under random credits
2C688 2C688 2C688 2C688 2C688 2C688 001 008 040 200 FFF 8D1 2 1 2650 78
# row ramp again with prompt credits
00000 09249 12492 1B6DB 24924 2DB6D 001 008 040 200 FFF 8D1 0 1 2675 79
# all pixels 1, result is the kernel weight sum
09249 09249 09249 09249 09249 09249 001 008 040 200 FFF 8D1 2 1 1050 16

/* list.f */
conv_pkg.sv
conv_matrix_store.sv
conv_kernel_store.sv
conv_window_engine.sv
conv_top.sv
tb_conv.sv

/* run.sh */
#!/bin/sh
# build and run the convolution engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_conv -f list.f -o sim_conv \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/sim_conv > "$LOG" 2>&1 \
    || { cat "$LOG"; echo "simulation exited with an error"; exit 1; }

cat "$LOG"
# the log decides the outcome
grep -q "SOME TESTS FAILED" "$LOG" && exit 1
grep -q "ALL TESTS PASSED" "$LOG" || { echo "no result line in $LOG"; exit 1; }
exit 0
